// ==== hw/vdp_cmd_pkg.sv ====
`default_nettype none

package vdp_cmd_pkg;

  // Field widths for the 256 x 212 byte-per-pixel mode
  localparam int X_W      = 8;
  localparam int Y_W      = 9;
  localparam int COLOUR_W = 8;
  localparam int NX_W     = 9;
  localparam int NY_W     = 10;

  typedef logic [X_W-1:0]       x_t;
  typedef logic [Y_W-1:0]       y_t;
  typedef logic [Y_W+X_W-1:0]   vram_addr_t;  // Row then column
  typedef logic [COLOUR_W-1:0]  colour_t;
  typedef logic [NX_W-1:0]      nx_t;
  typedef logic [NY_W-1:0]      ny_t;

  // Upper nibble of CMR, anything else is a no-op
  typedef enum logic [3:0] {
    CMD_PSET = 4'b0101,
    CMD_LMMV = 4'b1000,
    CMD_HMMV = 4'b1100
  } cmd_code_t;

  // Lower three bits of CMR; 5 to 7 keep the destination
  typedef enum logic [2:0] {
    OP_IMP = 3'd0,
    OP_AND = 3'd1,
    OP_OR  = 3'd2,
    OP_XOR = 3'd3,
    OP_NOT = 3'd4
  } logic_op_t;

  typedef struct packed {
    vram_addr_t addr;
    colour_t    colour;
    logic       read_first;   // Logical commands only
    logic_op_t  op;
    logic       transparent;
  } pixel_op_t;

  // Host register numbers
  localparam logic [3:0] REG_DX_LO = 4'd4;
  localparam logic [3:0] REG_DX_HI = 4'd5;
  localparam logic [3:0] REG_DY_LO = 4'd6;
  localparam logic [3:0] REG_DY_HI = 4'd7;
  localparam logic [3:0] REG_NX_LO = 4'd8;
  localparam logic [3:0] REG_NX_HI = 4'd9;
  localparam logic [3:0] REG_NY_LO = 4'd10;
  localparam logic [3:0] REG_NY_HI = 4'd11;
  localparam logic [3:0] REG_CLR   = 4'd12;
  localparam logic [3:0] REG_ARG   = 4'd13;
  localparam logic [3:0] REG_CMR   = 4'd14;

  localparam int FIFO_DEPTH = 4;
  localparam x_t X_LAST     = 8'd255;  // Right screen edge

endpackage

`default_nettype wire

// ==== hw/vdp_cmd_regs.sv ====
`default_nettype none

module vdp_cmd_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 reg_wr_req,
  input  logic [3:0]           reg_num,
  input  vdp_cmd_pkg::colour_t reg_data,
  output logic                 reg_wr_ack,
  input  logic                 walk_busy,
  input  logic                 fifo_empty,
  input  logic                 rmw_idle,
  output logic                 start,
  output vdp_cmd_pkg::x_t      dx,
  output vdp_cmd_pkg::y_t      dy,
  output vdp_cmd_pkg::nx_t     nx,
  output vdp_cmd_pkg::ny_t     ny,
  output vdp_cmd_pkg::colour_t clr,
  output logic [3:0]           arg,
  output logic [7:0]           cmd,
  output logic                 ce
);
  import vdp_cmd_pkg::*;

  logic wr_pending;
  logic cmd_busy;
  logic drained;

  assign wr_pending = reg_wr_req != reg_wr_ack;
  assign cmd_busy   = ce | start;  // Covers the cycle before ce rises
  assign drained    = !walk_busy && fifo_empty && rmw_idle;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      start      <= 1'b0;
      ce         <= 1'b0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      arg        <= '0;
      cmd        <= '0;
    end else begin
      start <= 1'b0;
      if (start) begin
        ce <= 1'b1;
      end else if (ce && drained) begin
        ce <= 1'b0;
      end

      if (wr_pending) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_DX_LO: dx <= reg_data;
          REG_DY_LO: dy[7:0] <= reg_data;
          REG_DY_HI: dy[8] <= reg_data[0];
          REG_NX_LO: nx[7:0] <= reg_data;
          REG_NX_HI: nx[8] <= reg_data[0];
          REG_NY_LO: ny[7:0] <= reg_data;
          REG_NY_HI: ny[9:8] <= reg_data[1:0];
          REG_CLR:   clr <= reg_data;
          REG_ARG:   arg <= reg_data[3:0];  // DIY, DIX, EQ, MM
          REG_CMR: begin
            // Dropped while a command runs
            if (!cmd_busy) begin
              cmd   <= reg_data;
              start <= 1'b1;
            end
          end
          default: ;  // Column high byte and unknown numbers
        endcase
      end
    end
  end

  // A second command must not restart the walker mid-flight
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> !ce);

endmodule

`default_nettype wire

// ==== hw/vdp_rect_walker.sv ====
`default_nettype none

module vdp_rect_walker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  vdp_cmd_pkg::x_t        dx,
  input  vdp_cmd_pkg::y_t        dy,
  input  vdp_cmd_pkg::nx_t       nx,
  input  vdp_cmd_pkg::ny_t       ny,
  input  vdp_cmd_pkg::colour_t   clr,
  input  logic [3:0]             arg,
  input  logic [7:0]             cmd,
  output logic                   op_valid,
  output vdp_cmd_pkg::pixel_op_t op,
  input  logic                   op_ready,
  output logic                   walk_busy
);
  import vdp_cmd_pkg::*;

  cmd_code_t code;
  logic      is_fill;
  logic      single;
  nx_t       nx_eff;
  ny_t       ny_eff;
  x_t        x;
  x_t        x_first;
  x_t        x_next;
  y_t        y;
  y_t        y_next;
  nx_t       nx_left;
  nx_t       nx_load;
  ny_t       ny_left;
  colour_t   colour;
  logic      dix;
  logic      diy;
  logic      read_first;
  logic_op_t lop;
  logic      transparent;
  logic      take;
  logic      row_end;
  logic      last;

  assign code    = cmd_code_t'(cmd[7:4]);
  assign is_fill = code inside {CMD_HMMV, CMD_LMMV, CMD_PSET};
  assign single  = code == CMD_PSET;
  assign nx_eff  = (single || nx == '0) ? nx_t'(1) : nx;  // Zero counts as one
  assign ny_eff  = (single || ny == '0) ? ny_t'(1) : ny;

  assign take    = op_valid && op_ready;
  assign x_next  = dix ? x - 1'b1 : x + 1'b1;
  assign y_next  = diy ? y - 1'b1 : y + 1'b1;
  assign row_end = (nx_left == nx_t'(1)) || (dix ? (x == '0) : (x == X_LAST));
  assign last    = row_end && ((ny_left == ny_t'(1)) || (diy && y == '0));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_valid <= 1'b0;
      x        <= '0;
      y        <= '0;
      nx_left  <= '0;
      ny_left  <= '0;
    end else if (start) begin
      op_valid <= is_fill;  // No-op commands finish here
      x        <= dx;
      y        <= dy;
      nx_left  <= nx_eff;
      ny_left  <= ny_eff;
    end else if (take) begin
      if (last) begin
        op_valid <= 1'b0;
      end else if (row_end) begin
        x       <= x_first;
        y       <= y_next;
        nx_left <= nx_load;
        ny_left <= ny_left - 1'b1;
      end else begin
        x       <= x_next;
        nx_left <= nx_left - 1'b1;
      end
    end
  end

  // Command fields held for the whole walk
  always_ff @(posedge clk) begin
    if (start) begin
      x_first     <= dx;
      nx_load     <= nx_eff;
      colour      <= clr;
      dix         <= arg[2];
      diy         <= arg[3];
      read_first  <= code != CMD_HMMV;
      lop         <= logic_op_t'(cmd[2:0]);
      transparent <= cmd[3] && code != CMD_HMMV;
    end
  end

  always_comb begin
    op.addr        = {y, x};
    op.colour      = colour;
    op.read_first  = read_first;
    op.op          = lop;
    op.transparent = transparent;
  end

  assign walk_busy = op_valid;

  // Relies on the register file never starting mid-walk
  a_op_hold: assert property (@(posedge clk) disable iff (reset)
    op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

`default_nettype wire

// ==== hw/vdp_op_fifo.sv ====
`default_nettype none

module vdp_op_fifo #(
  parameter type payload_t = vdp_cmd_pkg::pixel_op_t,
  parameter int  DEPTH     = vdp_cmd_pkg::FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = count != CNT_W'(DEPTH);  // Low while full
  assign empty     = count == '0;
  assign out_valid = !empty;
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    (count == CNT_W'(DEPTH)) && !pop |=> $stable(wr_ptr));
  a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
    empty && !push |=> $stable(rd_ptr) && empty);

endmodule

`default_nettype wire

// ==== hw/vdp_vram_rmw.sv ====
`default_nettype none

module vdp_vram_rmw (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    op_valid,
  input  vdp_cmd_pkg::pixel_op_t  op,
  output logic                    op_ready,
  output vdp_cmd_pkg::vram_addr_t vram_addr,
  output vdp_cmd_pkg::colour_t    vram_wr_data,
  output logic                    vram_rd_req,
  output logic                    vram_wr_req,
  input  logic                    vram_rd_ack,
  input  logic                    vram_wr_ack,
  input  vdp_cmd_pkg::colour_t    vram_rd_data,
  output logic                    idle
);
  import vdp_cmd_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RD_WAIT,
    ST_WR_WAIT
  } state_t;

  state_t    state;
  colour_t   src;
  logic_op_t lop;
  logic      transparent;
  colour_t   result;
  logic      accept;
  logic      rd_done;

  assign idle     = state == ST_IDLE;
  assign op_ready = idle;
  assign accept   = op_valid && op_ready;
  assign rd_done  = (state == ST_RD_WAIT) && (vram_rd_req == vram_rd_ack);

  // Source colour against the byte read back
  always_comb begin
    if (transparent && src == '0) begin
      result = vram_rd_data;
    end else begin
      case (lop)
        OP_IMP:  result = src;
        OP_AND:  result = src & vram_rd_data;
        OP_OR:   result = src | vram_rd_data;
        OP_XOR:  result = src ^ vram_rd_data;
        OP_NOT:  result = ~src;
        default: result = vram_rd_data;  // Reserved codes keep the pixel
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (op_valid) begin
            if (op.read_first) begin
              vram_rd_req <= ~vram_rd_req;
              state       <= ST_RD_WAIT;
            end else begin
              vram_wr_req <= ~vram_wr_req;  // HMMV goes straight to write
              state       <= ST_WR_WAIT;
            end
          end
        end
        ST_RD_WAIT: begin
          if (rd_done) begin
            vram_wr_req <= ~vram_wr_req;
            state       <= ST_WR_WAIT;
          end
        end
        ST_WR_WAIT: begin
          if (vram_wr_req == vram_wr_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      vram_addr    <= op.addr;
      vram_wr_data <= op.colour;
      src          <= op.colour;
      lop          <= op.op;
      transparent  <= op.transparent;
    end else if (rd_done) begin
      vram_wr_data <= result;
    end
  end

  a_addr_hold: assert property (@(posedge clk) disable iff (reset)
    ((vram_rd_req != vram_rd_ack) || (vram_wr_req != vram_wr_ack)) |=> $stable(vram_addr));

endmodule

`default_nettype wire

// ==== hw/vdp_cmd_engine.sv ====
`default_nettype none

module vdp_cmd_engine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    reg_wr_req,
  input  logic [3:0]              reg_num,
  input  vdp_cmd_pkg::colour_t    reg_data,
  output logic                    reg_wr_ack,
  output vdp_cmd_pkg::vram_addr_t vram_addr,
  output vdp_cmd_pkg::colour_t    vram_wr_data,
  output logic                    vram_rd_req,
  output logic                    vram_wr_req,
  input  logic                    vram_rd_ack,
  input  logic                    vram_wr_ack,
  input  vdp_cmd_pkg::colour_t    vram_rd_data,
  output logic                    ce
);
  import vdp_cmd_pkg::*;

  logic      start;
  x_t        dx;
  y_t        dy;
  nx_t       nx;
  ny_t       ny;
  colour_t   clr;
  logic [3:0] arg;
  logic [7:0] cmd;
  logic      walk_busy;
  logic      fifo_empty;
  logic      rmw_idle;
  logic      walk_valid;
  pixel_op_t walk_op;
  logic      walk_ready;
  logic      rmw_valid;
  pixel_op_t rmw_op;
  logic      rmw_ready;

  vdp_cmd_regs regs_i (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .reg_wr_ack,
    .walk_busy, .fifo_empty, .rmw_idle, .start,
    .dx, .dy, .nx, .ny, .clr, .arg, .cmd, .ce
  );

  vdp_rect_walker walker_i (
    .clk, .reset, .start, .dx, .dy, .nx, .ny, .clr, .arg, .cmd,
    .op_valid (walk_valid),
    .op       (walk_op),
    .op_ready (walk_ready),
    .walk_busy
  );

  vdp_op_fifo #(
    .payload_t (pixel_op_t),
    .DEPTH     (FIFO_DEPTH)
  ) op_fifo_i (
    .clk, .reset,
    .in_valid  (walk_valid),
    .in_data   (walk_op),
    .in_ready  (walk_ready),
    .out_valid (rmw_valid),
    .out_data  (rmw_op),
    .out_ready (rmw_ready),
    .empty     (fifo_empty)
  );

  vdp_vram_rmw rmw_i (
    .clk, .reset,
    .op_valid (rmw_valid),
    .op       (rmw_op),
    .op_ready (rmw_ready),
    .vram_addr, .vram_wr_data, .vram_rd_req, .vram_wr_req,
    .vram_rd_ack, .vram_wr_ack, .vram_rd_data,
    .idle     (rmw_idle)
  );

endmodule

`default_nettype wire

// ==== tb/vdp_cmd_checker.sv ====
`default_nettype none

module vdp_cmd_checker (
  input logic        clk,
  input logic        reset,
  input logic        ce,
  input logic [16:0] vram_addr,
  input logic [7:0]  vram_wr_data,
  input logic        vram_wr_req,
  input logic        vram_wr_ack
);

  logic [7:0]  mirror [0:(1 << 17) - 1];
  logic [16:0] exp_q [$];  // Addresses still to be written
  logic [7:0]  exp_cmd;
  logic [7:0]  exp_clr;
  logic        last_ack;
  logic        last_ce;
  logic        last_pending;  // Writes still owed at the previous edge
  int          errors;
  int          test_errors;
  int          test_num;
  int          writes;
  int          total_writes;

  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    return a[7:0] ^ a[15:8] ^ {a[16], 7'd0};
  endfunction

  // Expected pixel byte from the command, colour and old byte
  function automatic logic [7:0] expected_byte(input logic [7:0] cmd, input logic [7:0] clr,
                                               input logic [7:0] dst);
    if (cmd[7:4] == 4'b1100) begin
      return clr;
    end
    if (cmd[3] && clr == 8'h00) begin
      return dst;  // Transparent
    end
    case (cmd[2:0])
      3'd0:    return clr;
      3'd1:    return clr & dst;
      3'd2:    return clr | dst;
      3'd3:    return clr ^ dst;
      3'd4:    return ~clr;
      default: return dst;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < (1 << 17); i++) begin
      mirror[i] = fill_byte(17'(i));
    end
    errors       = 0;
    test_errors  = 0;
    test_num     = 1;
    writes       = 0;
    total_writes = 0;
    exp_cmd      = 8'h00;
    exp_clr      = 8'h00;
  end

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  // Walk order of the rectangle
  task automatic expect_command(input logic [7:0] dx, input logic [8:0] dy, input logic [8:0] nx,
                                input logic [9:0] ny, input logic [7:0] clr,
                                input logic [3:0] arg, input logic [7:0] cmd);
    int x;
    int y;
    int cols;
    int rows;
    exp_q.delete();
    exp_cmd = cmd;
    exp_clr = clr;
    if (!(cmd[7:4] inside {4'b1100, 4'b1000, 4'b0101})) begin
      return;
    end
    cols = (nx == 0) ? 1 : int'(nx);
    rows = (ny == 0) ? 1 : int'(ny);
    if (cmd[7:4] == 4'b0101) begin
      cols = 1;
      rows = 1;
    end
    y = dy;
    for (int r = 0; r < rows; r++) begin
      x = dx;
      for (int c = 0; c < cols; c++) begin
        exp_q.push_back({y[8:0], x[7:0]});
        if (arg[2] ? x == 0 : x == 255) break;
        x = arg[2] ? x - 1 : x + 1;
      end
      if (arg[3] && y == 0) break;
      y = arg[3] ? y - 1 : y + 1;
    end
  endtask

  task automatic check_write(input logic [16:0] addr, input logic [7:0] data);
    logic [16:0] want_addr;
    logic [7:0]  want;
    writes++;
    total_writes++;
    if (exp_q.size() == 0) begin
      $display("Extra write to address %h at time %0t, none was expected", addr, $time);
      note_error();
    end else begin
      want_addr = exp_q.pop_front();
      want      = expected_byte(exp_cmd, exp_clr, mirror[want_addr]);
      if (addr !== want_addr) begin
        $display("ERROR at %0t: write to address %h, expected address %h", $time, addr,
                 want_addr);
        note_error();
      end else if (data !== want) begin
        $display("ERROR at %0t: address %h got %h, expected %h", $time, addr, data, want);
        note_error();
      end
    end
    mirror[addr] = data;
  endtask

  task automatic finish_test(input string name);
    if (exp_q.size() != 0) begin
      $display("Test %0d is missing %0d pixel writes", test_num, exp_q.size());
      note_error();
      exp_q.delete();
    end
    $display("Test %0d %s: %0d writes, %s", test_num, name, writes,
             (test_errors == 0) ? "passed" : "failed");
    test_num++;
    writes      = 0;
    test_errors = 0;
  endtask

  // Compares each completed write, and checks ce against the drain
  always @(posedge clk) begin
    if (reset) begin
      last_ack     <= 1'b0;
      last_ce      <= 1'b0;
      last_pending <= 1'b0;
    end else begin
      if (vram_wr_ack != last_ack) begin
        check_write(vram_addr, vram_wr_data);
      end
      if (last_ce && !ce && last_pending) begin
        $display("ce fell at time %0t before every pixel write was acknowledged", $time);
        note_error();
      end
      last_ack     <= vram_wr_ack;
      last_ce      <= ce;
      last_pending <= exp_q.size() != 0 || vram_wr_req != vram_wr_ack;
    end
  end

endmodule

`default_nettype wire

// ==== tb/vdp_cmd_tb.sv ====
`default_nettype none

module vdp_cmd_tb;
  import vdp_cmd_pkg::*;

  logic        clk;
  logic        reset;
  logic        reg_wr_req;
  logic [3:0]  reg_num;
  logic [7:0]  reg_data;
  logic        reg_wr_ack;
  logic [16:0] vram_addr;
  logic [7:0]  vram_wr_data;
  logic        vram_rd_req;
  logic        vram_wr_req;
  logic        vram_rd_ack;
  logic        vram_wr_ack;
  logic [7:0]  vram_rd_data;
  logic        ce;

  logic [7:0]  vram [0:(1 << 17) - 1];
  logic        rd_busy;
  logic        wr_busy;
  int          rd_wait;
  int          wr_wait;
  logic        stall;  // Slow memory for the back-pressure test
  int          seed;
  int          tb_errors;

  vdp_cmd_engine dut_i (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .reg_wr_ack,
    .vram_addr, .vram_wr_data, .vram_rd_req, .vram_wr_req,
    .vram_rd_ack, .vram_wr_ack, .vram_rd_data, .ce
  );

  vdp_cmd_checker chk_i (
    .clk, .reset, .ce, .vram_addr, .vram_wr_data, .vram_wr_req, .vram_wr_ack
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    return a[7:0] ^ a[15:8] ^ {a[16], 7'd0};
  endfunction

  function automatic int draw_delay();
    if (stall) begin
      return 5;
    end
    return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
  endfunction

  initial begin
    for (int i = 0; i < (1 << 17); i++) begin
      vram[i] = fill_byte(17'(i));
    end
  end

  // VRAM model, answers each toggle request after a random delay
  always @(posedge clk) begin
    #2;
    if (!reset) begin
      if (vram_rd_req != vram_rd_ack) begin
        if (!rd_busy) begin
          rd_busy = 1'b1;
          rd_wait = draw_delay();
        end
        if (rd_wait == 0) begin
          vram_rd_data = vram[vram_addr];
          vram_rd_ack  = vram_rd_req;
          rd_busy      = 1'b0;
        end else begin
          rd_wait = rd_wait - 1;
        end
      end
      if (vram_wr_req != vram_wr_ack) begin
        if (!wr_busy) begin
          wr_busy = 1'b1;
          wr_wait = draw_delay();
        end
        if (wr_wait == 0) begin
          vram[vram_addr] = vram_wr_data;
          vram_wr_ack     = vram_wr_req;
          wr_busy         = 1'b0;
        end else begin
          wr_wait = wr_wait - 1;
        end
      end
    end
  end

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    int t;
    reg_num    = num;
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    t = 0;
    while (reg_wr_ack != reg_wr_req && t < 20) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (reg_wr_ack != reg_wr_req) begin
      $display("Timeout: register %0d write was never acknowledged", num);
      tb_errors++;
    end
  endtask

  task automatic wait_done(input int limit);
    int t;
    // ce comes up one cycle after the CMR acknowledge
    t = 0;
    while (!ce && t < 4) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (!ce) begin
      $display("Timeout: ce never rose after the command write");
      tb_errors++;
    end
    t = 0;
    while (ce && t < limit) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (ce) begin
      $display("Timeout: command still running after %0d cycles", limit);
      tb_errors++;
    end
  endtask

  // All command registers except CMR
  task automatic setup_rect(input logic [7:0] dx, input logic [8:0] dy, input logic [8:0] nx,
                            input logic [9:0] ny, input logic [7:0] clr,
                            input logic [3:0] arg, input logic [7:0] cmd);
    chk_i.expect_command(dx, dy, nx, ny, clr, arg, cmd);
    write_reg(REG_DX_LO, dx);
    write_reg(REG_DX_HI, 8'h00);  // Ignored by this mode
    write_reg(REG_DY_LO, dy[7:0]);
    write_reg(REG_DY_HI, {7'd0, dy[8]});
    write_reg(REG_NX_LO, nx[7:0]);
    write_reg(REG_NX_HI, {7'd0, nx[8]});
    write_reg(REG_NY_LO, ny[7:0]);
    write_reg(REG_NY_HI, {6'd0, ny[9:8]});
    write_reg(REG_CLR, clr);
    write_reg(REG_ARG, {4'd0, arg});
  endtask

  task automatic run_rect(input string name, input logic [7:0] dx, input logic [8:0] dy,
                          input logic [8:0] nx, input logic [9:0] ny, input logic [7:0] clr,
                          input logic [3:0] arg, input logic [7:0] cmd, input int limit);
    setup_rect(dx, dy, nx, ny, clr, arg, cmd);
    write_reg(REG_CMR, cmd);
    wait_done(limit);
    chk_i.finish_test(name);
  endtask

  initial begin
    logic [7:0] colour;
    reset        = 1'b1;
    reg_wr_req   = 1'b0;
    reg_num      = 4'd0;
    reg_data     = 8'd0;
    vram_rd_ack  = 1'b0;
    vram_wr_ack  = 1'b0;
    vram_rd_data = 8'd0;
    rd_busy      = 1'b0;
    wr_busy      = 1'b0;
    rd_wait      = 0;
    wr_wait      = 0;
    stall        = 1'b0;
    seed         = 5352;
    tb_errors    = 0;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;

    run_rect("HMMV 5x3", 8'd10, 9'd5, 9'd5, 10'd3, 8'hA5, 4'b0000, 8'hC0, 500);
    run_rect("LMMV DIX DIY to origin", 8'd2, 9'd2, 9'd10, 10'd10, 8'h55, 4'b1100, 8'h82, 500);
    for (int op = 0; op < 5; op++) begin
      colour = 8'h3C ^ (8'(op) * 8'h11);
      run_rect($sformatf("LMMV op %0d", op), 8'd40, 9'd20, 9'd4, 10'd2, colour, 4'b0000,
               {5'b10000, 3'(op)}, 500);
    end
    run_rect("LMMV TIMP clr 0", 8'd40, 9'd20, 9'd4, 10'd2, 8'h00, 4'b0000, 8'h88, 500);
    run_rect("PSET XOR", 8'd100, 9'd300, 9'd7, 10'd7, 8'h3C, 4'b0000, 8'h53, 200);

    // Right edge clip, with a second CMR write while busy
    setup_rect(8'd250, 9'd30, 9'd20, 10'd2, 8'h11, 4'b0000, 8'hC0);
    write_reg(REG_CMR, 8'hC0);
    write_reg(REG_CMR, 8'h80);
    if (!ce) begin
      $display("The second CMR write did not land while the command was running");
      tb_errors++;
    end
    wait_done(500);
    repeat (10) @(posedge clk);
    #2;
    if (ce) begin
      $display("The CMR write made during a command started a new command");
      tb_errors++;
    end
    chk_i.finish_test("Right edge and busy CMR");

    stall = 1'b1;
    run_rect("HMMV stalled memory", 8'd0, 9'd100, 9'd64, 10'd3, 8'hE7, 4'b0000, 8'hC0, 6000);
    stall = 1'b0;

    $display("Summary: %0d tests, %0d pixel writes, %0d checker failures, %0d handshake failures",
             chk_i.test_num - 1, chk_i.total_writes, chk_i.errors, tb_errors);
    if (chk_i.errors == 0 && tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/vdp_cmd_pkg.sv
hw/vdp_cmd_regs.sv
hw/vdp_rect_walker.sv
hw/vdp_op_fifo.sv
hw/vdp_vram_rmw.sv
hw/vdp_cmd_engine.sv
tb/vdp_cmd_checker.sv
tb/vdp_cmd_tb.sv

// ==== Bender.yml ====
package:
  name: vdp_cmd

sources:
  - hw/vdp_cmd_pkg.sv
  - hw/vdp_cmd_regs.sv
  - hw/vdp_rect_walker.sv
  - hw/vdp_op_fifo.sv
  - hw/vdp_vram_rmw.sv
  - hw/vdp_cmd_engine.sv
  - target: test
    files:
      - tb/vdp_cmd_checker.sv
      - tb/vdp_cmd_tb.sv
